// ==== hw/mrd_pkg.sv ====
package mrd_pkg;

	// memory banking
	localparam int N_BANKS     = 7;
	localparam int N_LANES     = 5;
	localparam int W_IDX       = 3;
	localparam int W_BANK_ADDR = 10;

	// bank index of a lane that is not used by the stage
	localparam logic [W_IDX-1:0] BANK_NONE = 3'd7;

	// sample and configuration widths
	localparam int W_SAMPLE = 16;
	localparam int W_RADIX  = 3;

	// wishbone bus widths
	localparam int W_WB_ADR = 14;
	localparam int W_WB_DAT = 32;

	// --------------------------------------------------
	// register map, word addresses
	// bit 13 clear selects a sample write
	// --------------------------------------------------
	localparam logic [W_WB_ADR-1:0] REG_RADIX = 14'h2000;
	localparam logic [W_WB_ADR-1:0] REG_SPAN  = 14'h2001;
	localparam logic [W_WB_ADR-1:0] REG_COUNT = 14'h2002;
	localparam logic [W_WB_ADR-1:0] REG_CTRL  = 14'h2003;

endpackage

// ==== hw/bank_div7.sv ====
`timescale 1ns/1ps

module bank_div7 import mrd_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic [ADDR_W-1:0]      addr,
	output logic [W_BANK_ADDR-1:0] bank_addr,
	output logic [W_IDX-1:0]       bank_idx
);

	localparam int W_PROD = ADDR_W + 16;

	logic [W_PROD-1:0] a_ext;
	logic [W_PROD-1:0] prod;
	logic [ADDR_W-1:0] q_est;
	logic [ADDR_W-1:0] r_est;
	logic [ADDR_W-1:0] q_fix;
	logic [ADDR_W-1:0] r_fix;

	// multiply by 9362, just below 2^16 / 7
	assign a_ext = W_PROD'(addr);
	assign prod  = (a_ext << 13) + (a_ext << 10) + (a_ext << 7)
		+ (a_ext << 4) + (a_ext << 1);
	assign q_est = prod[W_PROD-1:16];
	assign r_est = addr - ((q_est << 3) - q_est);

	// one step of remainder correction
	always_comb
	begin
		if (r_est >= ADDR_W'(N_BANKS))
		begin
			q_fix = q_est + ADDR_W'(1);
			r_fix = r_est - ADDR_W'(N_BANKS);
		end
		else
		begin
			q_fix = q_est;
			r_fix = r_est;
		end
	end

	assign bank_addr = W_BANK_ADDR'(q_fix);
	assign bank_idx  = W_IDX'(r_fix);

endmodule

// ==== hw/butterfly_addr_gen.sv ====
`timescale 1ns/1ps

module butterfly_addr_gen import mrd_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           go,
	input  logic [W_RADIX-1:0]             radix,
	input  logic [ADDR_W-1:0]              span,
	input  logic [ADDR_W-1:0]              count,
	output logic                           issue,
	output logic [N_LANES-1:0][ADDR_W-1:0] lane_addr
);

	logic [ADDR_W-1:0]              remain;
	logic [N_LANES-1:0][ADDR_W-1:0] lane_q;
	logic [N_LANES-1:0][ADDR_W-1:0] offset;
	logic                           start;

	assign start = go && !issue;

	// k * span as a chain of adders
	always_comb
	begin
		offset[0] = '0;
		for (int k = 1; k < N_LANES; k++)
			offset[k] = offset[k-1] + span;
	end

	// butterfly counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			issue  <= 1'b0;
			remain <= '0;
		end
		else if (start)
		begin
			issue  <= (count != '0);
			remain <= count;
		end
		else if (issue)
		begin
			issue  <= (remain != ADDR_W'(1));
			remain <= remain - ADDR_W'(1);
		end
	end

	// --------------------------------------------------
	// lane accumulators, j + k*span
	// --------------------------------------------------
	generate
		for (genvar k = 0; k < N_LANES; k++)
		begin : g_lane
			// unused lanes hold their last sum
			always_ff @(posedge clk)
			begin
				if (W_RADIX'(k) < radix)
				begin
					if (start)
						lane_q[k] <= offset[k];
					else if (issue)
						lane_q[k] <= lane_q[k] + ADDR_W'(1);
				end
			end
		end
	endgenerate

	assign lane_addr = lane_q;

endmodule

// ==== hw/bank_ram.sv ====
`timescale 1ns/1ps

module bank_ram import mrd_pkg::*; (
	input  logic                                clk,
	input  logic                                wr_en,
	input  logic [W_IDX-1:0]                    wr_bank,
	input  logic [W_BANK_ADDR-1:0]              wr_addr,
	input  logic [2*W_SAMPLE-1:0]               wr_data,
	input  logic [N_BANKS-1:0]                  rd_en,
	input  logic [N_BANKS-1:0][W_BANK_ADDR-1:0] rd_addr,
	output logic [N_BANKS-1:0][W_SAMPLE-1:0]    rd_real,
	output logic [N_BANKS-1:0][W_SAMPLE-1:0]    rd_imag
);

	localparam int DEPTH = 2 ** W_BANK_ADDR;

	generate
		for (genvar b = 0; b < N_BANKS; b++)
		begin : g_bank
			// real part in the upper half of each word
			logic [2*W_SAMPLE-1:0] mem [DEPTH];

			always_ff @(posedge clk)
			begin
				if (wr_en && wr_bank == W_IDX'(b))
					mem[wr_addr] <= wr_data;
			end

			// one cycle read latency
			always_ff @(posedge clk)
			begin
				if (rd_en[b])
				begin
					rd_real[b] <= mem[rd_addr[b]][2*W_SAMPLE-1:W_SAMPLE];
					rd_imag[b] <= mem[rd_addr[b]][W_SAMPLE-1:0];
				end
			end
		end
	endgenerate

endmodule

// ==== hw/stage_reader.sv ====
`timescale 1ns/1ps

module stage_reader import mrd_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                issue,
	input  logic [W_RADIX-1:0]                  radix,
	input  logic [N_LANES-1:0][ADDR_W-1:0]      lane_addr,
	output logic [N_BANKS-1:0]                  rd_en,
	output logic [N_BANKS-1:0][W_BANK_ADDR-1:0] rd_addr,
	input  logic [N_BANKS-1:0][W_SAMPLE-1:0]    rd_real,
	input  logic [N_BANKS-1:0][W_SAMPLE-1:0]    rd_imag,
	output logic [N_LANES-1:0][W_SAMPLE-1:0]    lane_real,
	output logic [N_LANES-1:0][W_SAMPLE-1:0]    lane_imag,
	output logic                                lane_valid,
	output logic                                stage_done,
	output logic                                busy
);

	logic [N_LANES-1:0][W_BANK_ADDR-1:0] div_addr;
	logic [N_LANES-1:0][W_IDX-1:0]       div_idx;
	logic [N_LANES-1:0][W_BANK_ADDR-1:0] addr_r;
	logic [N_LANES-1:0][W_IDX-1:0]       idx_r;
	logic [N_LANES-1:0][W_IDX-1:0]       idx_d1;
	logic [N_LANES-1:0][W_IDX-1:0]       idx_d2;
	logic [2:0]                          iss_sr;
	logic                                busy_q;

	// --------------------------------------------------
	// lane address to bank pair
	// --------------------------------------------------
	generate
		for (genvar k = 0; k < N_LANES; k++)
		begin : g_lane
			bank_div7 #(
				.ADDR_W (ADDR_W)
			) u_div7 (
				.addr      (lane_addr[k]),
				.bank_addr (div_addr[k]),
				.bank_idx  (div_idx[k])
			);

			always_ff @(posedge clk)
			begin
				addr_r[k] <= div_addr[k];
				idx_r[k]  <= (W_RADIX'(k) >= radix) ? BANK_NONE : div_idx[k];
			end
		end
	endgenerate

	// --------------------------------------------------
	// per bank read enable and address
	// --------------------------------------------------
	generate
		for (genvar b = 0; b < N_BANKS; b++)
		begin : g_bank
			logic                   hit;
			logic [W_BANK_ADDR-1:0] sel_addr;

			// lowest lane wins, a conflict-free stage has at most one hit
			always_comb
			begin
				hit      = 1'b0;
				sel_addr = '0;
				for (int k = N_LANES - 1; k >= 0; k--)
				begin
					if (idx_r[k] == W_IDX'(b))
					begin
						hit      = 1'b1;
						sel_addr = addr_r[k];
					end
				end
			end

			always_ff @(posedge clk)
			begin
				if (!rst_n)
					rd_en[b] <= 1'b0;
				else
					rd_en[b] <= hit && iss_sr[0];
			end

			always_ff @(posedge clk)
				rd_addr[b] <= sel_addr;
		end
	endgenerate

	// indices follow the data through the banks
	always_ff @(posedge clk)
	begin
		idx_d1 <= idx_r;
		idx_d2 <= idx_d1;
	end

	// steer bank outputs back to lanes
	always_comb
	begin
		for (int k = 0; k < N_LANES; k++)
		begin
			if (idx_d2[k] == BANK_NONE)
			begin
				lane_real[k] = '0;
				lane_imag[k] = '0;
			end
			else
			begin
				lane_real[k] = rd_real[idx_d2[k]];
				lane_imag[k] = rd_imag[idx_d2[k]];
			end
		end
	end

	// --------------------------------------------------
	// valid, done and busy framing
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			iss_sr     <= '0;
			stage_done <= 1'b0;
			busy_q     <= 1'b0;
		end
		else
		begin
			iss_sr     <= {iss_sr[1:0], issue};
			stage_done <= iss_sr[2] && !iss_sr[1];
			if (issue)
				busy_q <= 1'b1;
			else if (stage_done)
				busy_q <= 1'b0;
		end
	end

	assign lane_valid = iss_sr[2];
	assign busy       = busy_q || issue;

endmodule

// ==== hw/wb_ctrl_regs.sv ====
`timescale 1ns/1ps

module wb_ctrl_regs import mrd_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [W_WB_ADR-1:0]    adr,
	input  logic [W_WB_DAT-1:0]    dat_w,
	output logic                   ack,
	output logic [W_WB_DAT-1:0]    dat_r,
	input  logic                   busy,
	output logic                   go,
	output logic [W_RADIX-1:0]     radix,
	output logic [ADDR_W-1:0]      span,
	output logic [ADDR_W-1:0]      count,
	output logic                   wr_en,
	output logic [W_IDX-1:0]       wr_bank,
	output logic [W_BANK_ADDR-1:0] wr_addr,
	output logic [2*W_SAMPLE-1:0]  wr_data
);

	logic                   req;
	logic                   is_sample;
	logic [W_BANK_ADDR-1:0] pt_addr;
	logic [W_IDX-1:0]       pt_bank;

	assign req       = cyc && stb && !ack;
	assign is_sample = !adr[13];

	// write path bank mapping
	bank_div7 #(
		.ADDR_W (ADDR_W)
	) u_div7 (
		.addr      (adr[ADDR_W-1:0]),
		.bank_addr (pt_addr),
		.bank_idx  (pt_bank)
	);

	// --------------------------------------------------
	// ack, go and configuration registers
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack   <= 1'b0;
			go    <= 1'b0;
			wr_en <= 1'b0;
			radix <= W_RADIX'(1);
			span  <= ADDR_W'(1);
			count <= '0;
		end
		else
		begin
			ack   <= req;
			go    <= req && we && adr == REG_CTRL && dat_w[0] && !busy;
			// samples arriving mid-stage are dropped
			wr_en <= req && we && is_sample && !busy;
			if (req && we)
			begin
				if (adr == REG_RADIX)
					radix <= dat_w[W_RADIX-1:0];
				if (adr == REG_SPAN)
					span <= dat_w[ADDR_W-1:0];
				if (adr == REG_COUNT)
					count <= dat_w[ADDR_W-1:0];
			end
		end
	end

	// sample write lands in the ack cycle
	always_ff @(posedge clk)
	begin
		wr_bank <= pt_bank;
		wr_addr <= pt_addr;
		wr_data <= dat_w;
	end

	// read data
	always_ff @(posedge clk)
	begin
		case (adr)
			REG_RADIX: dat_r <= W_WB_DAT'(radix);
			REG_SPAN:  dat_r <= W_WB_DAT'(span);
			REG_COUNT: dat_r <= W_WB_DAT'(count);
			REG_CTRL:  dat_r <= W_WB_DAT'(busy);
			default:   dat_r <= '0;
		endcase
	end

endmodule

// ==== hw/mrd_read_top.sv ====
`timescale 1ns/1ps

module mrd_read_top import mrd_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             cyc,
	input  logic                             stb,
	input  logic                             we,
	input  logic [W_WB_ADR-1:0]              adr,
	input  logic [W_WB_DAT-1:0]              dat_w,
	output logic                             ack,
	output logic [W_WB_DAT-1:0]              dat_r,
	output logic [N_LANES-1:0][W_SAMPLE-1:0] lane_real,
	output logic [N_LANES-1:0][W_SAMPLE-1:0] lane_imag,
	output logic                             lane_valid,
	output logic                             stage_done
);

	logic                                go;
	logic                                busy;
	logic [W_RADIX-1:0]                  radix;
	logic [ADDR_W-1:0]                   span;
	logic [ADDR_W-1:0]                   count;
	logic                                issue;
	logic [N_LANES-1:0][ADDR_W-1:0]      lane_addr;
	logic [N_BANKS-1:0]                  rd_en;
	logic [N_BANKS-1:0][W_BANK_ADDR-1:0] rd_addr;
	logic [N_BANKS-1:0][W_SAMPLE-1:0]    rd_real;
	logic [N_BANKS-1:0][W_SAMPLE-1:0]    rd_imag;
	logic                                wr_en;
	logic [W_IDX-1:0]                    wr_bank;
	logic [W_BANK_ADDR-1:0]              wr_addr;
	logic [2*W_SAMPLE-1:0]               wr_data;

	wb_ctrl_regs #(
		.ADDR_W (ADDR_W)
	) u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.cyc     (cyc),
		.stb     (stb),
		.we      (we),
		.adr     (adr),
		.dat_w   (dat_w),
		.ack     (ack),
		.dat_r   (dat_r),
		.busy    (busy),
		.go      (go),
		.radix   (radix),
		.span    (span),
		.count   (count),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	butterfly_addr_gen #(
		.ADDR_W (ADDR_W)
	) u_agen (
		.clk       (clk),
		.rst_n     (rst_n),
		.go        (go),
		.radix     (radix),
		.span      (span),
		.count     (count),
		.issue     (issue),
		.lane_addr (lane_addr)
	);

	stage_reader #(
		.ADDR_W (ADDR_W)
	) u_reader (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.radix      (radix),
		.lane_addr  (lane_addr),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_real    (rd_real),
		.rd_imag    (rd_imag),
		.lane_real  (lane_real),
		.lane_imag  (lane_imag),
		.lane_valid (lane_valid),
		.stage_done (stage_done),
		.busy       (busy)
	);

	bank_ram u_banks (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_real (rd_real),
		.rd_imag (rd_imag)
	);

endmodule

// ==== sim/mrd_read_assert.sv ====
`timescale 1ns/1ps

module mrd_read_assert import mrd_pkg::*; #(
	parameter int ADDR_W = 12
) (
	input logic               clk,
	input logic               rst_n,
	input logic               cyc,
	input logic               stb,
	input logic               ack,
	input logic               issue,
	input logic [W_RADIX-1:0] radix,
	input logic [ADDR_W-1:0]  span,
	input logic [N_BANKS-1:0] rd_en,
	input logic               lane_valid,
	input logic               stage_done
);

	int fail_count = 0;

	// a span that is a multiple of seven puts two lanes on one bank
	a_span_banks: assert property (@(posedge clk) disable iff (!rst_n)
		issue && radix > 1 |-> (span % N_BANKS) != 0)
	else
	begin
		$error("stage span maps two lanes to one bank");
		fail_count++;
	end

	// every active lane gets a bank of its own
	a_bank_per_lane: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> ##2 ($countones(rd_en) == ((radix > N_LANES) ? N_LANES : int'(radix))))
	else
	begin
		$error("bank read enables do not match the active lanes");
		fail_count++;
	end

	// --------------------------------------------------
	// wishbone ack
	// --------------------------------------------------
	a_ack_resp: assert property (@(posedge clk) disable iff (!rst_n)
		cyc && stb && !ack |=> ack)
	else
	begin
		$error("request was not acked in the next cycle");
		fail_count++;
	end

	// last beat three cycles after the last issue, done right after it
	a_done_frame: assert property (@(posedge clk) disable iff (!rst_n)
		issue ##1 !issue |-> ##2 lane_valid ##1 (stage_done && !lane_valid))
	else
	begin
		$error("stage_done not right after the last lane_valid");
		fail_count++;
	end

endmodule

bind mrd_read_top mrd_read_assert #(
	.ADDR_W (ADDR_W)
) u_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.cyc        (cyc),
	.stb        (stb),
	.ack        (ack),
	.issue      (issue),
	.radix      (radix),
	.span       (span),
	.rd_en      (rd_en),
	.lane_valid (lane_valid),
	.stage_done (stage_done)
);

// ==== sim/tb_mrd_read.sv ====
`timescale 1ns/1ps

module tb_mrd_read import mrd_pkg::*; ();

	localparam int ADDR_W        = 12;
	localparam int ACK_TIMEOUT   = 20;
	localparam int STAGE_TIMEOUT = 5000;
	localparam int W_LANE_BUS    = N_LANES * W_SAMPLE;

	logic                             clk;
	logic                             rst_n;
	logic                             cyc;
	logic                             stb;
	logic                             we;
	logic [W_WB_ADR-1:0]              adr;
	logic [W_WB_DAT-1:0]              dat_w;
	logic                             ack;
	logic [W_WB_DAT-1:0]              dat_r;
	logic [N_LANES-1:0][W_SAMPLE-1:0] lane_real;
	logic [N_LANES-1:0][W_SAMPLE-1:0] lane_imag;
	logic                             lane_valid;
	logic                             stage_done;

	int                    cycle;
	int                    last_ack_cycle;
	int                    beats;
	int                    dones;
	int                    first_valid_cycle;
	int                    done_cycle;
	logic                  prev_valid;
	string                 test_name;
	logic [W_LANE_BUS-1:0] cap_real [$];
	logic [W_LANE_BUS-1:0] cap_imag [$];

	mrd_read_top #(
		.ADDR_W (ADDR_W)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.ack        (ack),
		.dat_r      (dat_r),
		.lane_real  (lane_real),
		.lane_imag  (lane_imag),
		.lane_valid (lane_valid),
		.stage_done (stage_done)
	);

	// 10 ns clock and a cycle count for timing checks
	initial
	begin
		clk   = 1'b0;
		cycle = 0;
		forever
		begin
			#5 clk = 1'b1;
			cycle = cycle + 1;
			#5 clk = 1'b0;
		end
	end

	// --------------------------------------------------
	// failure reporting and compares
	// --------------------------------------------------
	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input logic [W_SAMPLE-1:0] exp,
		input logic [W_SAMPLE-1:0] act);
		if (act !== exp)
			fail_stop($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_reg(input string name, input logic [W_WB_DAT-1:0] exp,
		input logic [W_WB_DAT-1:0] act);
		if (act !== exp)
			fail_stop($sformatf("Error: %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_stop($sformatf("Error: %s expected %b actual %b", name, exp, act));
	endtask

	// --------------------------------------------------
	// wishbone master
	// --------------------------------------------------
	task automatic bus_cycle(input logic write, input logic [W_WB_ADR-1:0] a,
		input logic [W_WB_DAT-1:0] d, output logic [W_WB_DAT-1:0] rdata);
		int waited;
		@(posedge clk);
		#1;
		cyc    = 1'b1;
		stb    = 1'b1;
		we     = write;
		adr    = a;
		dat_w  = d;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		while (!ack && waited < ACK_TIMEOUT);
		if (!ack)
			fail_stop($sformatf("no Wishbone ack for address %h in %s", a, test_name));
		rdata          = dat_r;
		last_ack_cycle = cycle;
		cyc            = 1'b0;
		stb            = 1'b0;
		we             = 1'b0;
	endtask

	task automatic write_word(input logic [W_WB_ADR-1:0] a, input logic [W_WB_DAT-1:0] d);
		logic [W_WB_DAT-1:0] unused;
		bus_cycle(1'b1, a, d, unused);
	endtask

	task automatic read_word(input logic [W_WB_ADR-1:0] a, output logic [W_WB_DAT-1:0] d);
		bus_cycle(1'b0, a, '0, d);
	endtask

	// lane stream capture, sampled after the outputs settle
	initial
	begin
		forever
		begin
			@(posedge clk);
			#2;
			if (rst_n)
			begin
				if (lane_valid)
				begin
					if (beats == 0)
						first_valid_cycle = cycle;
					cap_real.push_back(lane_real);
					cap_imag.push_back(lane_imag);
					beats++;
				end
				if (stage_done)
				begin
					check_flag({test_name, " stage_done after last lane_valid"}, 1'b1,
						prev_valid && !lane_valid);
					dones++;
					done_cycle = cycle;
				end
				prev_valid = lane_valid;
			end
		end
	end

	// --------------------------------------------------
	// one stage with busy probing and a second go
	// --------------------------------------------------
	task automatic run_stage(input int radix, input int span, input int count);
		logic [W_WB_DAT-1:0] rd;
		int                  waited;
		int                  go_cycle;
		check_reg({test_name, " unchecked beats"}, 0, cap_real.size());
		write_word(REG_RADIX, radix);
		write_word(REG_SPAN, span);
		write_word(REG_COUNT, count);
		beats             = 0;
		dones             = 0;
		first_valid_cycle = -1;
		done_cycle        = -1;
		cap_real.delete();
		cap_imag.delete();
		write_word(REG_CTRL, 32'h1);
		go_cycle = last_ack_cycle;
		read_word(REG_CTRL, rd);
		check_reg({test_name, " busy during stage"}, 32'h1, rd);
		// ignored while busy
		write_word(REG_CTRL, 32'h1);
		waited = 0;
		while (dones == 0 && waited < STAGE_TIMEOUT)
		begin
			@(posedge clk);
			#3;
			waited++;
		end
		if (dones == 0)
			fail_stop($sformatf("stage_done never came in %s", test_name));
		read_word(REG_CTRL, rd);
		check_reg({test_name, " busy after stage_done"}, 32'h0, rd);
		check_reg({test_name, " lane_valid count"}, count, beats);
		check_reg({test_name, " stage_done pulses"}, 1, dones);
		check_reg({test_name, " first lane_valid cycle"}, go_cycle + 4, first_valid_cycle);
		check_reg({test_name, " stage_done cycle"}, go_cycle + count + 4, done_cycle);
	endtask

	task automatic compare_beat(input logic [W_LANE_BUS-1:0] exp_real,
		input logic [W_LANE_BUS-1:0] exp_imag);
		logic [W_LANE_BUS-1:0] got_real;
		logic [W_LANE_BUS-1:0] got_imag;
		if (cap_real.size() == 0)
			fail_stop($sformatf("no lane beat left to compare in %s", test_name));
		got_real = cap_real.pop_front();
		got_imag = cap_imag.pop_front();
		for (int k = 0; k < N_LANES; k++)
		begin
			check_sample($sformatf("%s lane %0d real", test_name, k),
				exp_real[k*W_SAMPLE +: W_SAMPLE], got_real[k*W_SAMPLE +: W_SAMPLE]);
			check_sample($sformatf("%s lane %0d imag", test_name, k),
				exp_imag[k*W_SAMPLE +: W_SAMPLE], got_imag[k*W_SAMPLE +: W_SAMPLE]);
		end
	endtask

	// --------------------------------------------------
	// golden file records W, C, E and R
	// --------------------------------------------------
	task automatic read_golden();
		int                    fd;
		int                    n;
		int                    line_no;
		int                    stage_no;
		int                    cr;
		int                    cs;
		int                    cc;
		string                 line;
		byte                   kind;
		logic [W_WB_DAT-1:0]   a;
		logic [W_WB_DAT-1:0]   d;
		logic [W_WB_DAT-1:0]   rd;
		logic [W_SAMPLE-1:0]   er [N_LANES];
		logic [W_SAMPLE-1:0]   ei [N_LANES];
		logic [W_LANE_BUS-1:0] exp_real;
		logic [W_LANE_BUS-1:0] exp_imag;
		fd = $fopen("sim/mrd_read_golden.txt", "r");
		if (fd == 0)
			fail_stop("cannot open the golden file sim/mrd_read_golden.txt");
		line_no  = 0;
		stage_no = 0;
		while ($fgets(line, fd) != 0)
		begin
			line_no++;
			kind = line.getc(0);
			case (kind)
				"W":
				begin
					n = $sscanf(line, "W %h %h", a, d);
					if (n != 2)
						fail_stop($sformatf("bad sample record on golden line %0d", line_no));
					write_word(a[W_WB_ADR-1:0], d);
				end
				"C":
				begin
					n = $sscanf(line, "C %d %d %d", cr, cs, cc);
					if (n != 3)
						fail_stop($sformatf("bad stage record on golden line %0d", line_no));
					stage_no++;
					test_name = $sformatf("stage %0d radix %0d span %0d", stage_no, cr, cs);
					run_stage(cr, cs, cc);
				end
				"E":
				begin
					n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h", er[0], er[1],
						er[2], er[3], er[4], ei[0], ei[1], ei[2], ei[3], ei[4]);
					if (n != 10)
						fail_stop($sformatf("bad lane record on golden line %0d", line_no));
					for (int k = 0; k < N_LANES; k++)
					begin
						exp_real[k*W_SAMPLE +: W_SAMPLE] = er[k];
						exp_imag[k*W_SAMPLE +: W_SAMPLE] = ei[k];
					end
					test_name = $sformatf("stage %0d line %0d", stage_no, line_no);
					compare_beat(exp_real, exp_imag);
				end
				"R":
				begin
					n = $sscanf(line, "R %h %h", a, d);
					if (n != 2)
						fail_stop($sformatf("bad register record on golden line %0d", line_no));
					test_name = $sformatf("register %h line %0d", a[W_WB_ADR-1:0], line_no);
					read_word(a[W_WB_ADR-1:0], rd);
					check_reg(test_name, d, rd);
				end
				"#", "\n", "\r":
					;
				default:
					fail_stop($sformatf("unknown record kind on golden line %0d", line_no));
			endcase
		end
		$fclose(fd);
	endtask

	initial
	begin
		rst_n      = 1'b0;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = '0;
		dat_w      = '0;
		prev_valid = 1'b0;
		beats      = 0;
		dones      = 0;
		test_name  = "reset";
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		read_golden();
		check_reg("end of golden file unchecked beats", 0, cap_real.size());
		if (UUT.u_assert.fail_count == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("%0d bound assertion failures were reported", UUT.u_assert.fail_count);
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

// ==== verilog.f ====
hw/mrd_pkg.sv
hw/bank_div7.sv
hw/butterfly_addr_gen.sv
hw/bank_ram.sv
hw/stage_reader.sv
hw/wb_ctrl_regs.sv
hw/mrd_read_top.sv
sim/mrd_read_assert.sv
sim/tb_mrd_read.sv

// ==== sim/mrd_read_golden.txt ====
# W word_adr sample{real,imag} | C radix span count, decimal | R reg_adr expected
# E real lane0..lane4 then imag lane0..lane4 | all other fields hex
W 0000 10008000
W 0001 10018001
W 0002 10028002
W 0003 10038003
W 0004 10048004
W 0005 10058005
W 0006 10068006
W 0007 10078007
W 0008 10088008
W 0009 10098009
W 000a 100a800a
W 000b 100b800b
W 000c 100c800c
W 000d 100d800d
W 000e 100e800e
W 000f 100f800f
W 00fa 10fa80fa
W 00fb 10fb80fb
W 01f4 11f481f4
W 01f5 11f581f5
W 02ee 12ee82ee
W 02ef 12ef82ef
W 03e8 13e883e8
W 03e9 13e983e9
C 1 1 8
E 1000 0000 0000 0000 0000 8000 0000 0000 0000 0000
E 1001 0000 0000 0000 0000 8001 0000 0000 0000 0000
E 1002 0000 0000 0000 0000 8002 0000 0000 0000 0000
E 1003 0000 0000 0000 0000 8003 0000 0000 0000 0000
E 1004 0000 0000 0000 0000 8004 0000 0000 0000 0000
E 1005 0000 0000 0000 0000 8005 0000 0000 0000 0000
E 1006 0000 0000 0000 0000 8006 0000 0000 0000 0000
E 1007 0000 0000 0000 0000 8007 0000 0000 0000 0000
C 5 3 4
E 1000 1003 1006 1009 100c 8000 8003 8006 8009 800c
E 1001 1004 1007 100a 100d 8001 8004 8007 800a 800d
E 1002 1005 1008 100b 100e 8002 8005 8008 800b 800e
E 1003 1006 1009 100c 100f 8003 8006 8009 800c 800f
C 5 250 2
E 1000 10fa 11f4 12ee 13e8 8000 80fa 81f4 82ee 83e8
E 1001 10fb 11f5 12ef 13e9 8001 80fb 81f5 82ef 83e9
R 2001 000000fa
C 2 8 3
E 1000 1008 0000 0000 0000 8000 8008 0000 0000 0000
E 1001 1009 0000 0000 0000 8001 8009 0000 0000 0000
E 1002 100a 0000 0000 0000 8002 800a 0000 0000 0000
C 3 5 3
E 1000 1005 100a 0000 0000 8000 8005 800a 0000 0000
E 1001 1006 100b 0000 0000 8001 8006 800b 0000 0000
E 1002 1007 100c 0000 0000 8002 8007 800c 0000 0000
C 4 2 3
E 1000 1002 1004 1006 0000 8000 8002 8004 8006 0000
E 1001 1003 1005 1007 0000 8001 8003 8005 8007 0000
E 1002 1004 1006 1008 0000 8002 8004 8006 8008 0000
R 2000 00000004
R 2001 00000002
R 2002 00000003
R 2003 00000000
